// ==== logic/grf.sv ====
module grf (
	input  logic                 clk,
	input  logic                 rst,
	input  pipe_pkg::grf_write_t w_write,
	input  isa_pkg::reg_addr_t   ra_addr,
	input  isa_pkg::reg_addr_t   rb_addr,
	output isa_pkg::word_t       ra_data,
	output isa_pkg::word_t       rb_data
);

	// Register 0 has no storage
	isa_pkg::word_t regs [1:31];

	////////////////////
	// Write port
	////////////////////

	// Written at the edge, no bypass to the reads
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (w_write.we && (w_write.addr != '0)) begin
			// Writes to zero dropped here
			regs[w_write.addr] <= w_write.data;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Zero register reads as constant
	function automatic isa_pkg::word_t read_reg(input isa_pkg::reg_addr_t addr);
		isa_pkg::word_t val;
		if (addr == '0) begin
			val = '0;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	// Both ports purely combinational
	assign ra_data = read_reg(ra_addr);
	assign rb_data = read_reg(rb_addr);

endmodule

// ==== logic/isa_pkg.sv ====
package isa_pkg;

	////////////////////
	// Field types
	////////////////////

	// Whole instruction word
	typedef logic [31:0] instr_t;

	// Data word, also used for pc and ALU answer
	typedef logic [31:0] word_t;

	// Register number, rs/rt/rd fields
	typedef logic [4:0] reg_addr_t;

	// Top six bits of the word
	typedef logic [5:0] opcode_t;

	// Low six bits, only meaningful for special and swc
	typedef logic [5:0] funct_t;

	////////////////////
	// Opcodes
	////////////////////

	// R-type group, funct picks the operation
	localparam opcode_t op_special = 6'b000000;
	localparam opcode_t op_ori     = 6'b001101;
	localparam opcode_t op_lui     = 6'b001111;
	localparam opcode_t op_lw      = 6'b100011;
	localparam opcode_t op_sw      = 6'b101011;
	localparam opcode_t op_jal     = 6'b000011;
	// Custom op, needs fn_swc as well
	localparam opcode_t op_swc     = 6'b101010;

	////////////////////
	// Funct codes
	////////////////////

	localparam funct_t fn_add = 6'b100000;
	localparam funct_t fn_sub = 6'b100010;
	localparam funct_t fn_swc = 6'b101110;

	// Link register for jal
	localparam reg_addr_t reg_ra = 5'd31;

endpackage

// ==== logic/mem_stage.sv ====
module mem_stage #(
	// Data memory depth in words as a power of two
	parameter int dm_words = 256
) (
	input  logic                 clk,
	input  logic                 rst,
	input  isa_pkg::instr_t      m_instr,
	input  isa_pkg::word_t       m_pc,
	input  isa_pkg::word_t       m_ans,
	input  isa_pkg::word_t       m_store_data,
	output pipe_pkg::mw_bundle_t m_bundle,
	output isa_pkg::word_t       w_rdata
);

	// Word index width of at least one bit
	localparam int addr_bits = (dm_words > 1) ? $clog2(dm_words) : 1;

	////////////////////
	// Decode
	////////////////////

	isa_pkg::opcode_t m_op;
	logic             is_sw;

	assign m_op  = m_instr[31:26];
	assign is_sw = (m_op == isa_pkg::op_sw);

	////////////////////
	// Data memory
	////////////////////

	isa_pkg::word_t        dm [dm_words];
	logic [addr_bits-1:0]  dm_addr;

	// Byte address to word index
	// Upper bits wrap at the memory depth
	assign dm_addr = (dm_words > 1) ? m_ans[2 +: addr_bits] : '0;

	// Store on sw but not in reset
	always_ff @(posedge clk) begin
		if (!rst && is_sw) begin
			dm[dm_addr] <= m_store_data;
		end
	end

	// Read every cycle
	// Lands together with the instruction in mw_reg
	// Same-edge store not visible yet
	// Old word comes out
	always_ff @(posedge clk) begin
		w_rdata <= dm[dm_addr];
	end

	////////////////////
	// Hand-off
	////////////////////

	// Instruction moves on unchanged
	// ans carries the address for lw and sw and the result for the rest
	always_comb begin
		m_bundle.instr = m_instr;
		m_bundle.pc    = m_pc;
		m_bundle.ans   = m_ans;
	end

endmodule

// ==== logic/mw_reg.sv ====
module mw_reg (
	input  logic                 clk,
	input  logic                 rst,
	input  pipe_pkg::mw_bundle_t m_bundle,
	output pipe_pkg::mw_bundle_t w_bundle
);

	////////////////////
	// M/W boundary
	////////////////////

	// One edge of latency, no stall
	// Zero instruction after reset
	// All-zero word is a nop, writeback stays quiet
	always_ff @(posedge clk) begin
		if (rst) begin
			w_bundle <= '0;
		end else begin
			// Whole bundle moves every cycle
			w_bundle <= m_bundle;
		end
	end

endmodule

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

	////////////////////
	// Writeback selects
	////////////////////

	// Source of the register-file write data
	typedef logic [1:0] wdata_sel_t;
	localparam wdata_sel_t wdata_ans   = 2'b00;
	localparam wdata_sel_t wdata_rdata = 2'b01;
	// pc plus 8
	localparam wdata_sel_t wdata_link  = 2'b10;

	// Destination register choice
	typedef logic [1:0] wreg_sel_t;
	localparam wreg_sel_t wreg_rd = 2'b00;
	localparam wreg_sel_t wreg_rt = 2'b01;
	// Fixed register 31
	localparam wreg_sel_t wreg_ra = 2'b10;

	////////////////////
	// Stage bundles
	////////////////////

	// What crosses the M/W boundary, 96 bits
	typedef struct packed {
		isa_pkg::instr_t instr;
		isa_pkg::word_t  pc;
		isa_pkg::word_t  ans;
	} mw_bundle_t;

	// Decoded writeback controls
	typedef struct packed {
		logic                we;
		wdata_sel_t          wdata_sel;
		wreg_sel_t           wreg_sel;
		isa_pkg::reg_addr_t  rt;
		isa_pkg::reg_addr_t  rd;
		logic                is_lw;
	} w_ctrl_t;

	// Register-file write port, also the forwarding source
	typedef struct packed {
		logic               we;
		isa_pkg::reg_addr_t addr;
		isa_pkg::word_t     data;
	} grf_write_t;

endpackage

// ==== logic/w_controller.sv ====
module w_controller (
	input  isa_pkg::instr_t   w_instr,
	output pipe_pkg::w_ctrl_t w_ctrl
);

	////////////////////
	// Field split
	////////////////////

	isa_pkg::opcode_t w_op;
	isa_pkg::funct_t  w_fn;

	assign w_op = w_instr[31:26];
	assign w_fn = w_instr[5:0];

	////////////////////
	// Instruction match
	////////////////////

	logic is_special;
	logic is_add;
	logic is_sub;
	logic is_ori;
	logic is_lui;
	logic is_lw;
	logic is_jal;
	logic is_swc;

	// R-type group
	assign is_special = (w_op == isa_pkg::op_special);
	assign is_add     = is_special && (w_fn == isa_pkg::fn_add);
	assign is_sub     = is_special && (w_fn == isa_pkg::fn_sub);
	// I-type, opcode alone
	assign is_ori     = (w_op == isa_pkg::op_ori);
	assign is_lui     = (w_op == isa_pkg::op_lui);
	assign is_lw      = (w_op == isa_pkg::op_lw);
	assign is_jal     = (w_op == isa_pkg::op_jal);
	// Custom swc, both fields must match
	assign is_swc     = (w_op == isa_pkg::op_swc) && (w_fn == isa_pkg::fn_swc);

	////////////////////
	// Control outputs
	////////////////////

	always_comb begin
		// Writing set, nop and sw fall out
		w_ctrl.we = is_add | is_sub | is_ori | is_lui | is_lw | is_jal | is_swc;

		// Data source
		if (is_lw) begin
			w_ctrl.wdata_sel = pipe_pkg::wdata_rdata;
		end else if (is_jal) begin
			w_ctrl.wdata_sel = pipe_pkg::wdata_link;
		end else begin
			w_ctrl.wdata_sel = pipe_pkg::wdata_ans;
		end

		// Destination, rt for I-type writers
		if (is_ori | is_lui | is_lw) begin
			w_ctrl.wreg_sel = pipe_pkg::wreg_rt;
		end else if (is_jal) begin
			w_ctrl.wreg_sel = pipe_pkg::wreg_ra;
		end else begin
			w_ctrl.wreg_sel = pipe_pkg::wreg_rd;
		end

		// Raw register fields
		w_ctrl.rt    = w_instr[20:16];
		w_ctrl.rd    = w_instr[15:11];
		// Load-use hint for upstream
		w_ctrl.is_lw = is_lw;
	end

endmodule

// ==== logic/w_stage.sv ====
module w_stage (
	input  pipe_pkg::mw_bundle_t w_bundle,
	input  isa_pkg::word_t       w_rdata,
	output pipe_pkg::grf_write_t w_write,
	output logic                 w_is_lw
);

	pipe_pkg::w_ctrl_t  w_ctrl;
	isa_pkg::word_t     w_link;
	isa_pkg::reg_addr_t w_dest;
	isa_pkg::word_t     w_data;

	// Decoder sees only the instruction
	w_controller u_w_controller (
		.w_instr (w_bundle.instr),
		.w_ctrl  (w_ctrl)
	);

	////////////////////
	// Writeback muxes
	////////////////////

	// Return address, past the delay slot
	assign w_link = w_bundle.pc + 32'd8;

	// Destination register
	always_comb begin
		case (w_ctrl.wreg_sel)
			pipe_pkg::wreg_rt: w_dest = w_ctrl.rt;
			pipe_pkg::wreg_ra: w_dest = isa_pkg::reg_ra;
			default:           w_dest = w_ctrl.rd;
		endcase
	end

	// Write data
	always_comb begin
		case (w_ctrl.wdata_sel)
			pipe_pkg::wdata_rdata: w_data = w_rdata;
			pipe_pkg::wdata_link:  w_data = w_link;
			default:               w_data = w_bundle.ans;
		endcase
	end

	// Register-file port, also leaves for forwarding
	assign w_write.we   = w_ctrl.we;
	assign w_write.addr = w_dest;
	assign w_write.data = w_data;
	assign w_is_lw      = w_ctrl.is_lw;

endmodule

// ==== logic/wb_top.sv ====
module wb_top #(
	// Data memory depth in words
	parameter int dm_words = 256
) (
	input  logic                 clk,
	input  logic                 rst,
	// Memory-stage inputs, from E/M upstream
	input  isa_pkg::instr_t      m_instr,
	input  isa_pkg::word_t       m_pc,
	input  isa_pkg::word_t       m_ans,
	input  isa_pkg::word_t       m_store_data,
	// Decode-stage register reads
	input  isa_pkg::reg_addr_t   ra_addr,
	input  isa_pkg::reg_addr_t   rb_addr,
	output isa_pkg::word_t       ra_data,
	output isa_pkg::word_t       rb_data,
	// Writeback view for forwarding and hazards
	output pipe_pkg::grf_write_t w_write,
	output logic                 w_is_lw
);

	pipe_pkg::mw_bundle_t m_bundle;
	pipe_pkg::mw_bundle_t w_bundle;
	isa_pkg::word_t       w_rdata;

	////////////////////
	// Memory stage
	////////////////////

	mem_stage #(
		.dm_words (dm_words)
	) u_mem_stage (
		.clk          (clk),
		.rst          (rst),
		.m_instr      (m_instr),
		.m_pc         (m_pc),
		.m_ans        (m_ans),
		.m_store_data (m_store_data),
		.m_bundle     (m_bundle),
		.w_rdata      (w_rdata)
	);

	// Stage boundary
	mw_reg u_mw_reg (
		.clk      (clk),
		.rst      (rst),
		.m_bundle (m_bundle),
		.w_bundle (w_bundle)
	);

	////////////////////
	// Writeback stage
	////////////////////

	// Read data bypasses mw_reg, already one edge late
	w_stage u_w_stage (
		.w_bundle (w_bundle),
		.w_rdata  (w_rdata),
		.w_write  (w_write),
		.w_is_lw  (w_is_lw)
	);

	grf u_grf (
		.clk     (clk),
		.rst     (rst),
		.w_write (w_write),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_wb -f verilog.f \
	|| { echo "Build failed"; exit 1; }
./obj_dir/Vtb_wb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "^Everything OK$" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== tests/tb_clock.sv ====
module tb_clock #(
	// Full clock period in time units
	parameter int period = 8
) (
	output logic clk
);

	// Free-running, low for the first half period
	always begin
		clk = 1'b0;
		#(period / 2);
		clk = 1'b1;
		#(period / 2);
	end

endmodule

// ==== tests/tb_wb.sv ====
module tb_wb;

	localparam int dm_words    = 64;
	localparam int drain_limit = 20;

	logic                 clk;
	logic                 rst;
	isa_pkg::instr_t      m_instr;
	isa_pkg::word_t       m_pc;
	isa_pkg::word_t       m_ans;
	isa_pkg::word_t       m_store_data;
	isa_pkg::reg_addr_t   ra_addr;
	isa_pkg::reg_addr_t   rb_addr;
	isa_pkg::word_t       ra_data;
	isa_pkg::word_t       rb_data;
	pipe_pkg::grf_write_t w_write;
	logic                 w_is_lw;

	tb_clock #(.period(8)) u_clock (.clk(clk));

	wb_top #(.dm_words(dm_words)) u_dut (
		.clk(clk), .rst(rst), .m_instr(m_instr), .m_pc(m_pc), .m_ans(m_ans),
		.m_store_data(m_store_data), .ra_addr(ra_addr), .rb_addr(rb_addr),
		.ra_data(ra_data), .rb_data(rb_data), .w_write(w_write), .w_is_lw(w_is_lw)
	);

	////////////////////
	// Shadow model
	////////////////////

	isa_pkg::word_t       sh_regs [32];
	isa_pkg::word_t       sh_mem [dm_words];
	// Writes in flight, newest and one step older
	pipe_pkg::grf_write_t slot_new;
	pipe_pkg::grf_write_t slot_old;
	logic [31:0]          seed;
	int                   test_errs;
	int                   tests_passed;
	int                   tests_failed;
	int                   props_seen;
	logic                 hung;

	// LCG, full 32-bit state
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic isa_pkg::reg_addr_t rand_reg();
		logic [31:0] r;
		r = next_random();
		return r[31:27];
	endfunction

	// Register write that the instruction should cause
	function automatic pipe_pkg::grf_write_t expect_write(input isa_pkg::instr_t instr,
			input isa_pkg::word_t pc, input isa_pkg::word_t ans, input isa_pkg::word_t rdata);
		pipe_pkg::grf_write_t wr;
		isa_pkg::opcode_t     op;
		isa_pkg::funct_t      fn;
		op = instr[31:26];
		fn = instr[5:0];
		wr = '0;
		if ((op == isa_pkg::op_special && (fn == isa_pkg::fn_add || fn == isa_pkg::fn_sub))
				|| (op == isa_pkg::op_swc && fn == isa_pkg::fn_swc)) begin
			wr.we   = 1'b1;
			wr.addr = instr[15:11];
			wr.data = ans;
		end else if (op == isa_pkg::op_ori || op == isa_pkg::op_lui || op == isa_pkg::op_lw) begin
			wr.we   = 1'b1;
			wr.addr = instr[20:16];
			wr.data = (op == isa_pkg::op_lw) ? rdata : ans;
		end else if (op == isa_pkg::op_jal) begin
			wr.we   = 1'b1;
			wr.addr = 5'd31;
			wr.data = pc + 32'd8;
		end
		return wr;
	endfunction

	task automatic check_port(input string name, input isa_pkg::word_t got,
			input isa_pkg::word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
			test_errs++;
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	// One cycle, reads checked before new inputs go out
	task automatic step(input isa_pkg::instr_t instr, input isa_pkg::word_t pc,
			input isa_pkg::word_t ans, input isa_pkg::word_t sd,
			input isa_pkg::reg_addr_t ra, input isa_pkg::reg_addr_t rb);
		int idx;
		@(negedge clk);
		// Two edges old, now in the register file
		if (slot_old.we && slot_old.addr != 5'd0) begin
			sh_regs[slot_old.addr] = slot_old.data;
		end
		check_port("ra_data", ra_data, sh_regs[ra_addr]);
		check_port("rb_data", rb_data, sh_regs[rb_addr]);
		// Word index wraps at the memory depth
		idx = int'((ans >> 2) % dm_words);
		slot_old = slot_new;
		// Load sees stores of earlier steps only
		slot_new = expect_write(instr, pc, ans, sh_mem[idx]);
		if (instr[31:26] == isa_pkg::op_sw) begin
			sh_mem[idx] = sd;
		end
		m_instr      = instr;
		m_pc         = pc;
		m_ans        = ans;
		m_store_data = sd;
		ra_addr      = ra;
		rb_addr      = rb;
	endtask

	task automatic idle_step(input isa_pkg::reg_addr_t ra, input isa_pkg::reg_addr_t rb);
		step('0, '0, '0, '0, ra, rb);
	endtask

	// Every register through the read ports
	task automatic sweep_regs();
		for (int i = 0; i < 16; i++) begin
			idle_step(isa_pkg::reg_addr_t'(2 * i), isa_pkg::reg_addr_t'(2 * i + 1));
		end
	endtask

	// Nops until writeback goes quiet
	task automatic drain();
		int n;
		n = 0;
		idle_step(rand_reg(), rand_reg());
		idle_step(rand_reg(), rand_reg());
		while (w_write.we !== 1'b0 && !hung) begin
			if (n >= drain_limit) begin
				$display("Timeout: writeback still writing after %0d idle cycles", n);
				hung = 1'b1;
			end else begin
				idle_step(rand_reg(), rand_reg());
				n++;
			end
		end
		idle_step(rand_reg(), rand_reg());
	endtask

	task automatic finish_test(input string name);
		int errs;
		// Assertion failures since the last test count too
		errs = test_errs + (u_dut.u_props.fail_count - props_seen);
		props_seen = u_dut.u_props.fail_count;
		if (errs == 0) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errs);
		end
		test_errs = 0;
	endtask

	// Stops the run after a timeout
	always @(posedge clk) begin
		if (hung) begin
			$display("Something failed");
			$finish;
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		isa_pkg::instr_t    instr;
		isa_pkg::word_t     pc;
		isa_pkg::word_t     ans;
		isa_pkg::word_t     sd;
		isa_pkg::reg_addr_t rd;
		isa_pkg::reg_addr_t last;
		logic [31:0]        r;
		logic [31:0]        f;
		int                 pick;
		rst = 1'b1;
		m_instr = '0;
		m_pc = '0;
		m_ans = '0;
		m_store_data = '0;
		ra_addr = '0;
		rb_addr = '0;
		seed = 32'd29;
		hung = 1'b0;
		test_errs = 0;
		tests_passed = 0;
		tests_failed = 0;
		props_seen = 0;
		slot_new = '0;
		slot_old = '0;
		pc = 32'h0000_3000;
		last = '0;
		for (int i = 0; i < 32; i++) begin
			sh_regs[i] = '0;
		end
		repeat (16) @(negedge clk);
		rst = 1'b0;

		// Nothing written, all registers zero
		sweep_regs();
		drain();
		finish_test("reset");

		// R-type writers, one hit on register 0
		for (int i = 0; i < 12; i++) begin
			rd = (i == 5) ? 5'd0 : rand_reg();
			ans = next_random();
			case (i % 3)
				0: instr = {isa_pkg::op_special, rand_reg(), rand_reg(), rd, 5'd0, isa_pkg::fn_add};
				1: instr = {isa_pkg::op_special, rand_reg(), rand_reg(), rd, 5'd0, isa_pkg::fn_sub};
				default: instr = {isa_pkg::op_swc, rand_reg(), rand_reg(), rd, 5'd0, isa_pkg::fn_swc};
			endcase
			step(instr, pc, ans, next_random(), last, rd);
			last = rd;
			pc = pc + 32'd4;
		end
		drain();
		finish_test("add_sub_swc");

		// rt written, rd field left alone
		for (int i = 0; i < 8; i++) begin
			rd = rand_reg();
			f = next_random();
			instr = {(i[0] ? isa_pkg::op_lui : isa_pkg::op_ori), rand_reg(), rd, f[15:0]};
			step(instr, pc, next_random(), '0, last, f[15:11]);
			last = rd;
		end
		drain();
		finish_test("ori_lui");

		// Store then load of the same word
		for (int i = 0; i < 6; i++) begin
			ans = next_random();
			sd = next_random();
			rd = rand_reg();
			step({isa_pkg::op_sw, rand_reg(), rand_reg(), ans[15:0]}, pc, ans, sd, rd, rd);
			step({isa_pkg::op_lw, rand_reg(), rd, ans[15:0]}, pc, ans, '0, rd, rd);
			idle_step(rd, rd);
		end
		drain();
		finish_test("sw_lw");

		// Link value, other fields random
		for (int i = 0; i < 5; i++) begin
			f = next_random();
			pc = next_random() & 32'hffff_fffc;
			step({isa_pkg::op_jal, f[25:0]}, pc, next_random(), next_random(), 5'd31, 5'd31);
		end
		drain();
		finish_test("jal");

		// Known word everywhere before random loads
		for (int i = 0; i < dm_words; i++) begin
			sd = (isa_pkg::word_t'(i) * 32'h0101_0101) ^ 32'hc3a5_0f1e;
			step({isa_pkg::op_sw, 26'd0}, pc, isa_pkg::word_t'(i) << 2, sd, '0, '0);
		end
		for (int i = 0; i < 60; i++) begin
			r = next_random();
			f = next_random();
			pick = int'(r[31:24]) % 10;
			case (pick)
				0: instr = {isa_pkg::op_special, f[25:6], isa_pkg::fn_add};
				1: instr = {isa_pkg::op_special, f[25:6], isa_pkg::fn_sub};
				2: instr = {isa_pkg::op_swc, f[25:6], isa_pkg::fn_swc};
				3: instr = {isa_pkg::op_ori, f[25:0]};
				4: instr = {isa_pkg::op_lui, f[25:0]};
				5: instr = {isa_pkg::op_lw, f[25:0]};
				6: instr = {isa_pkg::op_jal, f[25:0]};
				7: instr = {isa_pkg::op_sw, f[25:0]};
				// nop or a beq
				8: instr = f[0] ? {6'b000100, f[25:0]} : '0;
				// swc opcode with the wrong funct
				default: instr = {isa_pkg::op_swc, f[25:6], isa_pkg::fn_add};
			endcase
			pc = next_random() & 32'hffff_fffc;
			step(instr, pc, next_random(), next_random(), rand_reg(), rand_reg());
		end
		drain();
		sweep_regs();
		drain();
		finish_test("random_stream");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== tests/wb_properties.sv ====
module wb_properties (
	input logic                 clk,
	input logic                 rst,
	input isa_pkg::instr_t      m_instr,
	input isa_pkg::word_t       m_pc,
	input isa_pkg::word_t       m_ans,
	input pipe_pkg::grf_write_t w_write,
	input logic                 w_is_lw
);

	// Failed assertion count, read by the testbench
	int fail_count = 0;

	isa_pkg::opcode_t op;
	isa_pkg::funct_t  fn;
	logic             is_arith;
	logic             is_imm;
	logic             is_load;
	logic             is_link;
	logic             is_writer;

	////////////////////
	// Memory-stage view
	////////////////////

	assign op = m_instr[31:26];
	assign fn = m_instr[5:0];
	// add, sub and swc write rd with the answer
	assign is_arith = (op == isa_pkg::op_special && (fn == isa_pkg::fn_add
		|| fn == isa_pkg::fn_sub)) || (op == isa_pkg::op_swc && fn == isa_pkg::fn_swc);
	assign is_imm    = (op == isa_pkg::op_ori) || (op == isa_pkg::op_lui);
	assign is_load   = (op == isa_pkg::op_lw);
	assign is_link   = (op == isa_pkg::op_jal);
	assign is_writer = is_arith | is_imm | is_load | is_link;

	////////////////////
	// Writeback rules
	////////////////////

	// Quiet writeback straight out of reset
	a_reset_quiet: assert property (@(posedge clk) rst |=> !w_write.we && !w_is_lw)
		else begin fail_count++; $error("writeback active after reset"); end

	// Words outside the writing set never write
	a_no_stray: assert property (@(posedge clk) disable iff (rst) !is_writer |=> !w_write.we)
		else begin fail_count++; $error("write after a non-writing word"); end

	// ori and lui go to rt
	a_imm_rt: assert property (@(posedge clk) disable iff (rst)
		is_imm |=> w_write.we && w_write.addr == $past(m_instr[20:16]))
		else begin fail_count++; $error("ori or lui not written to rt"); end

	// R-type writers, rd gets the answer
	a_arith_rd: assert property (@(posedge clk) disable iff (rst)
		is_arith |=> w_write.we && w_write.addr == $past(m_instr[15:11])
		&& w_write.data == $past(m_ans))
		else begin fail_count++; $error("add, sub or swc write wrong"); end

	// Load flag exactly one cycle later
	a_lw_flag: assert property (@(posedge clk) disable iff (rst)
		is_load |=> w_is_lw && w_write.we && w_write.addr == $past(m_instr[20:16]))
		else begin fail_count++; $error("lw flag or destination wrong"); end

	a_lw_only: assert property (@(posedge clk) disable iff (rst) !is_load |=> !w_is_lw)
		else begin fail_count++; $error("lw flag raised for another word"); end

	// Return address into register 31
	a_jal_link: assert property (@(posedge clk) disable iff (rst)
		is_link |=> w_write.we && w_write.addr == isa_pkg::reg_ra
		&& w_write.data == $past(m_pc) + 32'd8)
		else begin fail_count++; $error("jal link write wrong"); end

endmodule

bind wb_top wb_properties u_props (
	.clk     (clk),
	.rst     (rst),
	.m_instr (m_instr),
	.m_pc    (m_pc),
	.m_ans   (m_ans),
	.w_write (w_write),
	.w_is_lw (w_is_lw)
);

// ==== verilog.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/mem_stage.sv
logic/mw_reg.sv
logic/w_controller.sv
logic/w_stage.sv
logic/grf.sv
logic/wb_top.sv
tests/tb_clock.sv
tests/wb_properties.sv
tests/tb_wb.sv
